// File: verilog/stage_types_pkg.sv
package stage_types_pkg;

    ////////////////////////////////////////////////////////////
    // Word widths and fixed-point format
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH = 16;

    // Weight of 1 << FRAC_BITS is unity gain
    localparam int FRAC_BITS = 8;

    typedef logic signed [DATA_WIDTH-1:0]   pixel_t;
    typedef logic signed [DATA_WIDTH-1:0]   weight_t;
    typedef logic signed [2*DATA_WIDTH-1:0] product_t;

    // Clamp limits for any result written back as a pixel
    localparam pixel_t PIXEL_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    localparam pixel_t PIXEL_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    ////////////////////////////////////////////////////////////
    // Stream beats
    ////////////////////////////////////////////////////////////

    // One pixel beat, sampled whenever valid is high
    typedef struct packed {
        logic   valid;
        pixel_t data;
    } pixel_stream_t;

    // One write into a weight slot
    typedef struct packed {
        logic    valid;
        weight_t value;
    } weight_stream_t;

endpackage

// File: verilog/stage_config_pkg.sv
package stage_config_pkg;

    ////////////////////////////////////////////////////////////
    // Stage structure
    ////////////////////////////////////////////////////////////

    // Identity blocks chained behind the conv block
    localparam int NUM_ID_BLOCKS = 2;

    // Slot order: main 1, main 2, shortcut
    localparam int CONV_WEIGHTS = 3;
    // Slot order: main 1, main 2, main 3
    localparam int ID_WEIGHTS = 3;

    localparam int NUM_WEIGHTS = CONV_WEIGHTS + NUM_ID_BLOCKS * ID_WEIGHTS;

    ////////////////////////////////////////////////////////////
    // Latencies in clock cycles
    ////////////////////////////////////////////////////////////

    localparam int CONV_LATENCY = 3;
    localparam int ID_LATENCY = 4;

    localparam int STAGE_LATENCY = CONV_LATENCY + NUM_ID_BLOCKS * ID_LATENCY;

endpackage

// File: verilog/scale_unit.sv
`timescale 1ns/10ps

module scale_unit #(
    parameter bit APPLY_RELU = 1'b1
) (
    input  logic                           clk,
    input  logic                           rst,
    input  stage_types_pkg::weight_stream_t weight,
    input  stage_types_pkg::pixel_stream_t  pixel_in,
    output stage_types_pkg::pixel_stream_t  pixel_out
);

    import stage_types_pkg::*;

    weight_t  weight_q;
    product_t product;
    product_t shifted;
    pixel_t   result;
    pixel_t   data_q;
    logic     valid_q;

    // Weight slot, written straight from its stream
    always_ff @(posedge clk) begin
        if (rst) begin
            weight_q <= '0;
        end else if (weight.valid) begin
            weight_q <= weight.value;
        end
    end

    // Full-width signed product, then drop the fraction bits
    assign product = pixel_in.data * weight_q;
    assign shifted = product >>> FRAC_BITS;

    // Clamp to pixel range, then optional rectify
    always_comb begin
        if (shifted > product_t'(PIXEL_MAX)) begin
            result = PIXEL_MAX;
        end else if (shifted < product_t'(PIXEL_MIN)) begin
            result = PIXEL_MIN;
        end else begin
            result = pixel_t'(shifted);
        end
        if (APPLY_RELU && result < 0) begin
            result = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pixel_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_in.valid) begin
            data_q <= result;
        end
    end

    assign pixel_out.valid = valid_q;
    assign pixel_out.data  = data_q;

endmodule

// File: verilog/skip_delay.sv
`timescale 1ns/10ps

module skip_delay #(
    parameter int DEPTH = 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  stage_types_pkg::pixel_stream_t pixel_in,
    output stage_types_pkg::pixel_stream_t pixel_out
);

    import stage_types_pkg::*;

    logic   [DEPTH-1:0] valid_sr;
    pixel_t [DEPTH-1:0] data_sr;

    // Valid pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= pixel_in.valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    // Data moves every cycle to stay in step with valid
    always_ff @(posedge clk) begin
        data_sr[0] <= pixel_in.data;
        for (int i = 1; i < DEPTH; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

    assign pixel_out.valid = valid_sr[DEPTH-1];
    assign pixel_out.data  = data_sr[DEPTH-1];

endmodule

// File: verilog/residual_add.sv
`timescale 1ns/10ps

module residual_add (
    input  logic                          clk,
    input  logic                          rst,
    input  stage_types_pkg::pixel_stream_t main_in,
    input  stage_types_pkg::pixel_stream_t skip_in,
    output stage_types_pkg::pixel_stream_t pixel_out
);

    import stage_types_pkg::*;

    // One extra bit so the sum cannot wrap
    logic signed [DATA_WIDTH:0] sum;
    pixel_t                     result;
    pixel_t                     data_q;
    logic                       valid_q;

    assign sum = main_in.data + skip_in.data;

    // Saturate then ReLU; the low clamp is swallowed by the ReLU
    always_comb begin
        if (sum > $signed({1'b0, PIXEL_MAX})) begin
            result = PIXEL_MAX;
        end else if (sum < 0) begin
            result = '0;
        end else begin
            result = pixel_t'(sum);
        end
    end

    // Main valid marks the beat
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= main_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (main_in.valid && skip_in.valid) begin
            data_q <= result;
        end
    end

    assign pixel_out.valid = valid_q;
    assign pixel_out.data  = data_q;

endmodule

// File: verilog/conv_block.sv
`timescale 1ns/10ps

module conv_block (
    input  logic                          clk,
    input  logic                          rst,
    input  stage_types_pkg::pixel_stream_t pixel_in,
    input  stage_types_pkg::weight_stream_t [stage_config_pkg::CONV_WEIGHTS-1:0] weights,
    output stage_types_pkg::pixel_stream_t pixel_out
);

    import stage_types_pkg::*;
    import stage_config_pkg::*;

    // Shortcut scale is one step shorter than the main path
    localparam int SKIP_DEPTH = CONV_LATENCY - 2;

    pixel_stream_t main_1;
    pixel_stream_t main_2;
    pixel_stream_t skip_scaled;
    pixel_stream_t skip_aligned;

    ////////////////////////////////////////////////////////////
    // Main path
    ////////////////////////////////////////////////////////////

    scale_unit #(
        .APPLY_RELU(1'b1)
    ) u_main_1 (
        .clk      (clk),
        .rst      (rst),
        .weight   (weights[0]),
        .pixel_in (pixel_in),
        .pixel_out(main_1)
    );

    // Last main step stays signed
    scale_unit #(
        .APPLY_RELU(1'b0)
    ) u_main_2 (
        .clk      (clk),
        .rst      (rst),
        .weight   (weights[1]),
        .pixel_in (main_1),
        .pixel_out(main_2)
    );

    ////////////////////////////////////////////////////////////
    // Projection shortcut
    ////////////////////////////////////////////////////////////

    scale_unit #(
        .APPLY_RELU(1'b0)
    ) u_skip_scale (
        .clk      (clk),
        .rst      (rst),
        .weight   (weights[2]),
        .pixel_in (pixel_in),
        .pixel_out(skip_scaled)
    );

    skip_delay #(
        .DEPTH(SKIP_DEPTH)
    ) u_skip_delay (
        .clk      (clk),
        .rst      (rst),
        .pixel_in (skip_scaled),
        .pixel_out(skip_aligned)
    );

    // Merge
    residual_add u_add (
        .clk      (clk),
        .rst      (rst),
        .main_in  (main_2),
        .skip_in  (skip_aligned),
        .pixel_out(pixel_out)
    );

endmodule

// File: verilog/identity_block.sv
`timescale 1ns/10ps

module identity_block (
    input  logic                          clk,
    input  logic                          rst,
    input  stage_types_pkg::pixel_stream_t pixel_in,
    input  stage_types_pkg::weight_stream_t [stage_config_pkg::ID_WEIGHTS-1:0] weights,
    output stage_types_pkg::pixel_stream_t pixel_out
);

    import stage_types_pkg::*;
    import stage_config_pkg::*;

    // Shortcut must match the three main steps
    localparam int SKIP_DEPTH = ID_LATENCY - 1;

    pixel_stream_t main_1;
    pixel_stream_t main_2;
    pixel_stream_t main_3;
    pixel_stream_t skip_aligned;

    ////////////////////////////////////////////////////////////
    // Main path
    ////////////////////////////////////////////////////////////

    scale_unit #(
        .APPLY_RELU(1'b1)
    ) u_main_1 (
        .clk      (clk),
        .rst      (rst),
        .weight   (weights[0]),
        .pixel_in (pixel_in),
        .pixel_out(main_1)
    );

    scale_unit #(
        .APPLY_RELU(1'b1)
    ) u_main_2 (
        .clk      (clk),
        .rst      (rst),
        .weight   (weights[1]),
        .pixel_in (main_1),
        .pixel_out(main_2)
    );

    // No ReLU before the sum
    scale_unit #(
        .APPLY_RELU(1'b0)
    ) u_main_3 (
        .clk      (clk),
        .rst      (rst),
        .weight   (weights[2]),
        .pixel_in (main_2),
        .pixel_out(main_3)
    );

    ////////////////////////////////////////////////////////////
    // Identity shortcut, input pixel unscaled
    ////////////////////////////////////////////////////////////

    skip_delay #(
        .DEPTH(SKIP_DEPTH)
    ) u_skip_delay (
        .clk      (clk),
        .rst      (rst),
        .pixel_in (pixel_in),
        .pixel_out(skip_aligned)
    );

    residual_add u_add (
        .clk      (clk),
        .rst      (rst),
        .main_in  (main_3),
        .skip_in  (skip_aligned),
        .pixel_out(pixel_out)
    );

endmodule

// File: verilog/residual_stage.sv
`timescale 1ns/10ps

module residual_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  stage_types_pkg::pixel_stream_t pixel_in,
    input  stage_types_pkg::weight_stream_t [stage_config_pkg::NUM_WEIGHTS-1:0] weights,
    output stage_types_pkg::pixel_stream_t pixel_out
);

    import stage_types_pkg::*;
    import stage_config_pkg::*;

    // Block boundaries; entry 0 is the conv block output
    pixel_stream_t [NUM_ID_BLOCKS:0] stage_link;

    ////////////////////////////////////////////////////////////
    // Conv block, weight slots 0 .. CONV_WEIGHTS-1
    ////////////////////////////////////////////////////////////

    conv_block u_conv (
        .clk      (clk),
        .rst      (rst),
        .pixel_in (pixel_in),
        .weights  (weights[CONV_WEIGHTS-1:0]),
        .pixel_out(stage_link[0])
    );

    ////////////////////////////////////////////////////////////
    // Identity chain
    ////////////////////////////////////////////////////////////

    // Each block takes the next ID_WEIGHTS slots in chain order
    for (genvar g = 0; g < NUM_ID_BLOCKS; g++) begin : g_id
        identity_block u_id (
            .clk      (clk),
            .rst      (rst),
            .pixel_in (stage_link[g]),
            .weights  (weights[CONV_WEIGHTS + g*ID_WEIGHTS +: ID_WEIGHTS]),
            .pixel_out(stage_link[g+1])
        );
    end

    assign pixel_out = stage_link[NUM_ID_BLOCKS];

endmodule

// File: verification/residual_stage_tb.sv
`timescale 1ns/10ps

module residual_stage_tb;

    import stage_types_pkg::*;
    import stage_config_pkg::*;

    localparam int NUM_ROWS    = 7;
    localparam int MAX_PIX     = 6;
    localparam int DRAIN_LIMIT = 100;

    // One table row holds weights for every slot and a pixel burst
    typedef struct packed {
        weight_t [NUM_WEIGHTS-1:0] w;
        pixel_t  [MAX_PIX-1:0]     pix;
        logic    [MAX_PIX-1:0]     gap;
        int                        n;
    } test_row_t;

    logic                                 clk;
    logic                                 rst;
    pixel_stream_t                        pixel_in;
    weight_stream_t [NUM_WEIGHTS-1:0]     weights;
    pixel_stream_t                        pixel_out;

    test_row_t table_rows[NUM_ROWS];
    weight_t   cur_w[NUM_WEIGHTS];
    pixel_t    exp_q[$];
    int        stamp_q[$];
    pixel_t    exp_data;
    int        exp_stamp;
    int        cycle = 0;
    int        seed = 32'h89e1_5da4;

    residual_stage uut (
        .clk      (clk),
        .rst      (rst),
        .pixel_in (pixel_in),
        .weights  (weights),
        .pixel_out(pixel_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic pixel_t scale_step(pixel_t x, weight_t w, bit relu);
        longint prod;
        prod = (longint'(x) * longint'(w)) >>> FRAC_BITS;
        if (prod > longint'(PIXEL_MAX)) begin
            prod = longint'(PIXEL_MAX);
        end else if (prod < longint'(PIXEL_MIN)) begin
            prod = longint'(PIXEL_MIN);
        end
        if (relu && prod < 0) begin
            prod = 0;
        end
        return pixel_t'(prod);
    endfunction

    function automatic pixel_t add_relu(pixel_t a, pixel_t b);
        int s;
        s = int'(a) + int'(b);
        if (s > int'(PIXEL_MAX)) begin
            s = int'(PIXEL_MAX);
        end
        if (s < 0) begin
            s = 0;
        end
        return pixel_t'(s);
    endfunction

    function automatic pixel_t model_stage(pixel_t x);
        pixel_t blk;
        pixel_t m;
        int     base;
        m   = scale_step(x, cur_w[0], 1'b1);
        m   = scale_step(m, cur_w[1], 1'b0);
        blk = add_relu(m, scale_step(x, cur_w[2], 1'b0));
        for (int b = 0; b < NUM_ID_BLOCKS; b++) begin
            base = CONV_WEIGHTS + b * ID_WEIGHTS;
            m    = scale_step(blk, cur_w[base], 1'b1);
            m    = scale_step(m, cur_w[base+1], 1'b1);
            m    = scale_step(m, cur_w[base+2], 1'b0);
            blk  = add_relu(m, blk);
        end
        return blk;
    endfunction

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic add_beat(input int r, input pixel_t p, input logic g);
        table_rows[r].pix[table_rows[r].n] = p;
        table_rows[r].gap[table_rows[r].n] = g;
        table_rows[r].n = table_rows[r].n + 1;
    endtask

    task automatic load_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            table_rows[r] = '0;
            table_rows[r].w = {NUM_WEIGHTS{weight_t'(256)}};
        end
        // Single pixel at unity gain for latency
        add_beat(0, 100, 1'b0);
        // Back to back and gapped beats at unity gain
        add_beat(1, -50, 1'b0);
        add_beat(1, 10, 1'b0);
        add_beat(1, 300, 1'b1);
        add_beat(1, 7, 1'b0);
        add_beat(1, 1000, 1'b1);
        // Gain of 16 per step drives everything into the clamp
        table_rows[2].w = {NUM_WEIGHTS{weight_t'(4096)}};
        add_beat(2, 30000, 1'b0);
        add_beat(2, 5, 1'b0);
        add_beat(2, 12345, 1'b0);
        // Negative last steps and shortcut, sums go below zero
        table_rows[3].w[1] = -256;
        table_rows[3].w[2] = -256;
        table_rows[3].w[5] = -512;
        table_rows[3].w[8] = -512;
        add_beat(3, 100, 1'b0);
        add_beat(3, 400, 1'b1);
        add_beat(3, 7, 1'b0);
        // Reload with fractional gains
        table_rows[4].w = {NUM_WEIGHTS{weight_t'(128)}};
        table_rows[4].w[2] = 384;
        table_rows[4].w[4] = 512;
        add_beat(4, 1000, 1'b0);
        add_beat(4, -300, 1'b1);
        add_beat(4, 64, 1'b0);
        add_beat(4, 20000, 1'b0);
        for (int r = 5; r < NUM_ROWS; r++) begin
            for (int k = 0; k < NUM_WEIGHTS; k++) begin
                table_rows[r].w[k] = weight_t'($random(seed) % 640);
            end
            for (int i = 0; i < MAX_PIX; i++) begin
                add_beat(r, pixel_t'($random(seed) % 8192), logic'($random(seed) & 1));
            end
        end
    endtask

    // Stage must be idle here
    task automatic write_weights(input int r);
        @(negedge clk);
        for (int k = 0; k < NUM_WEIGHTS; k++) begin
            weights[k].valid = 1'b1;
            weights[k].value = table_rows[r].w[k];
            cur_w[k] = table_rows[r].w[k];
        end
        @(negedge clk);
        for (int k = 0; k < NUM_WEIGHTS; k++) begin
            weights[k].valid = 1'b0;
        end
    endtask

    task automatic stream_row(input int r);
        for (int i = 0; i < table_rows[r].n; i++) begin
            @(negedge clk);
            pixel_in.valid = 1'b1;
            pixel_in.data  = table_rows[r].pix[i];
            exp_q.push_back(model_stage(table_rows[r].pix[i]));
            stamp_q.push_back(cycle);
            if (table_rows[r].gap[i]) begin
                @(negedge clk);
                pixel_in.valid = 1'b0;
            end
        end
        @(negedge clk);
        pixel_in.valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else abort_run("Timed out waiting for output beats");
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor and stray beat check
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && pixel_out.valid) begin
            assert (exp_q.size() != 0) else abort_run("Output beat with no pixel outstanding");
            if (exp_q.size() != 0) begin
                exp_data  = exp_q.pop_front();
                exp_stamp = stamp_q.pop_front();
                assert (pixel_out.data === exp_data) else begin
                    $display("Error at %0t: pixel_out.data expected %0d, got %0d",
                             $time, exp_data, pixel_out.data);
                    abort_run("Output value mismatch");
                end
                assert (cycle - exp_stamp == STAGE_LATENCY) else begin
                    $display("Error at %0t: latency expected %0d, got %0d",
                             $time, STAGE_LATENCY, cycle - exp_stamp);
                    abort_run("Output beat arrived at the wrong cycle");
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        pixel_in = '0;
        weights  = '0;
        load_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Idle period where any output valid is a stray beat
        repeat (20) @(negedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            write_weights(r);
            stream_row(r);
            wait_drain();
        end
        repeat (5) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: all.f
verilog/stage_types_pkg.sv
verilog/stage_config_pkg.sv
verilog/scale_unit.sv
verilog/skip_delay.sv
verilog/residual_add.sv
verilog/conv_block.sv
verilog/identity_block.sv
verilog/residual_stage.sv
verification/residual_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the residual stage testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log
SIM=residual_stage_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module residual_stage_tb -f all.f -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASS" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
